/* design/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path width
`define XLEN 32

// destination tag width, sized for the tags in flight
`define TAG_W 4

// reservation station entries
// 2 and 8 also work
`define RS_DEPTH 4

// shift amount bits taken from operand b
`define SHAMT_W 5

`endif

/* design/exec_pkg.sv */
`include "exec_cfg.svh"

package exec_pkg;

	// alu operation, decoded upstream
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,
		ALU_SRL  = 4'h6,
		ALU_SRA  = 4'h7,
		ALU_SLT  = 4'h8,
		ALU_SLTU = 4'h9
	} alu_func_e;

	// operand a source
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1,
		OPA_IS_ZERO = 2'h2
	} opa_sel_e;

	// operand b source
	typedef enum logic {
		OPB_IS_RS2 = 1'b0,
		OPB_IS_IMM = 1'b1
	} opb_sel_e;

	// one source operand, waits on tag until ready
	typedef struct packed {
		logic [`XLEN-1:0]  value;
		logic [`TAG_W-1:0] tag;
		logic              ready;
	} src_operand_t;

	typedef struct packed {
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  imm; // already sign extended
		alu_func_e         alu_func;
		opa_sel_e          opa_select;
		opb_sel_e          opb_select;
		logic [`TAG_W-1:0] dest_tag;
		src_operand_t      src1;
		src_operand_t      src2;
	} dispatch_packet_t;

	// both sources resolved by the time it leaves the station
	typedef struct packed {
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  imm;
		alu_func_e         alu_func;
		opa_sel_e          opa_select;
		opb_sel_e          opb_select;
		logic [`TAG_W-1:0] dest_tag;
		logic [`XLEN-1:0]  rs1_value;
		logic [`XLEN-1:0]  rs2_value;
	} issue_packet_t;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`XLEN-1:0]  value;
	} result_packet_t;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module alu (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   refresh,
	input  logic                   in_valid,
	input  logic [`XLEN-1:0]       opa,
	input  logic [`XLEN-1:0]       opb,
	input  exec_pkg::alu_func_e    func,
	input  logic [`TAG_W-1:0]      in_tag,
	output logic                   valid,
	output exec_pkg::result_packet_t result
);

	logic [`XLEN-1:0]    alu_out;
	logic [`SHAMT_W-1:0] shamt;

	assign shamt = opb[`SHAMT_W-1:0]; // low bits only

	always_comb begin
		case (func)
			exec_pkg::ALU_ADD:  alu_out = opa + opb;
			exec_pkg::ALU_SUB:  alu_out = opa - opb;
			exec_pkg::ALU_AND:  alu_out = opa & opb;
			exec_pkg::ALU_OR:   alu_out = opa | opb;
			exec_pkg::ALU_XOR:  alu_out = opa ^ opb;
			exec_pkg::ALU_SLL:  alu_out = opa << shamt;
			exec_pkg::ALU_SRL:  alu_out = opa >> shamt;
			exec_pkg::ALU_SRA:  alu_out = $signed(opa) >>> shamt; // sign fill
			exec_pkg::ALU_SLT: begin
				alu_out = `XLEN'($signed(opa) < $signed(opb));
			end
			exec_pkg::ALU_SLTU: begin
				alu_out = `XLEN'(opa < opb);
			end
			default:            alu_out = '0;
		endcase
	end

	// valid is the only control bit here
	always_ff @(posedge clock) begin
		if (reset || refresh) begin
			valid <= 1'b0;
		end else begin
			valid <= in_valid;
		end
	end

	// value and tag move together
	always_ff @(posedge clock) begin
		if (in_valid) begin
			result.tag   <= in_tag;
			result.value <= alu_out;
		end
	end

endmodule

/* design/fu_alu.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module fu_alu (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     squash,
	input  logic                     issue_valid,
	input  exec_pkg::issue_packet_t  issue,
	output logic                     result_valid,
	output exec_pkg::result_packet_t result
);

	// instruction held for the alu stage
	exec_pkg::issue_packet_t work;
	logic                    work_valid;

	logic [`XLEN-1:0] opa_mux_out;
	logic [`XLEN-1:0] opb_mux_out;

	// takes a new issue every cycle, no stall
	always_ff @(posedge clock) begin
		if (reset || squash) begin
			work_valid <= 1'b0;
			work       <= '0;
		end else begin
			work_valid <= issue_valid;
			if (issue_valid) begin
				work <= issue;
			end
		end
	end

	// operand a
	always_comb begin
		case (work.opa_select)
			exec_pkg::OPA_IS_RS1:  opa_mux_out = work.rs1_value;
			exec_pkg::OPA_IS_PC:   opa_mux_out = work.pc;
			exec_pkg::OPA_IS_ZERO: opa_mux_out = '0;
			default:               opa_mux_out = '0; // unused encoding
		endcase
	end

	// operand b, imm comes in sign extended
	always_comb begin
		case (work.opb_select)
			exec_pkg::OPB_IS_RS2: opb_mux_out = work.rs2_value;
			exec_pkg::OPB_IS_IMM: opb_mux_out = work.imm;
			default:              opb_mux_out = work.rs2_value;
		endcase
	end

	// second stage of the unit
	// squash drops whatever the alu is computing
	alu i_alu (
		.clock    (clock),
		.reset    (reset),
		.refresh  (squash),
		.in_valid (work_valid),
		.opa      (opa_mux_out),
		.opb      (opb_mux_out),
		.func     (work.alu_func),
		.in_tag   (work.dest_tag),
		.valid    (result_valid),
		.result   (result)
	);

endmodule

/* design/res_station.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module res_station (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       squash,
	input  logic                       dispatch_valid,
	input  exec_pkg::dispatch_packet_t dispatch,
	input  logic                       broadcast_valid,
	input  exec_pkg::result_packet_t   broadcast,
	output logic                       issue_valid,
	output exec_pkg::issue_packet_t    issue,
	output logic                       rs_full
);

	localparam int IDX_W = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

	exec_pkg::dispatch_packet_t entry [`RS_DEPTH];
	logic [`RS_DEPTH-1:0]       busy;
	logic [`RS_DEPTH-1:0]       ready;

	logic [IDX_W-1:0]           free_idx;
	logic [IDX_W-1:0]           sel_idx;
	logic                       accept;
	exec_pkg::dispatch_packet_t dispatch_fwd;

	assign rs_full = &busy;
	assign accept  = dispatch_valid && !rs_full; // dispatch during full is dropped

	// a source waiting on the tag being broadcast right now grabs it directly
	always_comb begin
		dispatch_fwd = dispatch;
		if (broadcast_valid && !dispatch.src1.ready && dispatch.src1.tag == broadcast.tag) begin
			dispatch_fwd.src1.value = broadcast.value;
			dispatch_fwd.src1.ready = 1'b1;
		end
		if (broadcast_valid && !dispatch.src2.ready && dispatch.src2.tag == broadcast.tag) begin
			dispatch_fwd.src2.value = broadcast.value;
			dispatch_fwd.src2.ready = 1'b1;
		end
	end

	// lowest free entry
	always_comb begin
		free_idx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			ready[i] = busy[i] && entry[i].src1.ready && entry[i].src2.ready;
		end
	end

	// lowest ready entry wins
	always_comb begin
		sel_idx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel_idx = IDX_W'(i);
			end
		end
	end

	// issue goes straight from the entry, fu_alu latches it at the edge
	// that frees the entry
	assign issue_valid = |ready;

	always_comb begin
		issue.pc         = entry[sel_idx].pc;
		issue.imm        = entry[sel_idx].imm;
		issue.alu_func   = entry[sel_idx].alu_func;
		issue.opa_select = entry[sel_idx].opa_select;
		issue.opb_select = entry[sel_idx].opb_select;
		issue.dest_tag   = entry[sel_idx].dest_tag;
		issue.rs1_value  = entry[sel_idx].src1.value;
		issue.rs2_value  = entry[sel_idx].src2.value;
	end

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			busy <= '0;
		end else begin
			if (issue_valid) begin
				busy[sel_idx] <= 1'b0;
			end
			if (accept) begin
				busy[free_idx] <= 1'b1; // never the entry issuing, that one is busy
			end
		end
	end

	// entry contents, qualified by busy
	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (accept && free_idx == IDX_W'(i)) begin
				entry[i] <= dispatch_fwd;
			end else if (busy[i] && broadcast_valid) begin
				if (!entry[i].src1.ready && entry[i].src1.tag == broadcast.tag) begin
					entry[i].src1.value <= broadcast.value;
					entry[i].src1.ready <= 1'b1;
				end
				if (!entry[i].src2.ready && entry[i].src2.tag == broadcast.tag) begin
					entry[i].src2.value <= broadcast.value;
					entry[i].src2.ready <= 1'b1;
				end
			end
		end
	end

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       squash,
	input  logic                       dispatch_valid,
	input  exec_pkg::dispatch_packet_t dispatch,
	output logic                       rs_full,
	output logic                       result_valid,
	output exec_pkg::result_packet_t   result
);

	logic                    issue_valid;
	exec_pkg::issue_packet_t issue;

	// result also serves as the wakeup broadcast
	res_station i_res_station (
		.clock           (clock),
		.reset           (reset),
		.squash          (squash),
		.dispatch_valid  (dispatch_valid),
		.dispatch        (dispatch),
		.broadcast_valid (result_valid),
		.broadcast       (result),
		.issue_valid     (issue_valid),
		.issue           (issue),
		.rs_full         (rs_full)
	);

	fu_alu i_fu_alu (
		.clock        (clock),
		.reset        (reset),
		.squash       (squash),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* test/exec_unit_properties.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_unit_properties (
	input logic clock,
	input logic reset,
	input logic squash,
	input logic dispatch_valid,
	input logic rs_full,
	input logic result_valid
);

	// outputs settle to idle one edge after reset
	reset_clears_outputs: assert property (@(posedge clock)
		reset |=> (!rs_full && !result_valid))
		else $error("rs_full or result_valid high in the cycle after reset");

	// dispatcher has to hold off while the station is full
	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		dispatch_valid |-> !rs_full)
		else $error("dispatch_valid raised while rs_full is high");

	squash_kills_result: assert property (@(posedge clock) disable iff (reset)
		squash |=> !result_valid)
		else $error("result_valid high in the cycle after squash");

endmodule

bind exec_unit exec_unit_properties i_properties (
	.clock          (clock),
	.reset          (reset),
	.squash         (squash),
	.dispatch_valid (dispatch_valid),
	.rs_full        (rs_full),
	.result_valid   (result_valid)
);

/* test/exec_unit_tb.sv */
`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_unit_tb;

	localparam int N_INDEP     = 200;
	localparam int N_SELECT    = 36;
	localparam int N_CHAINS    = 8;
	localparam int CHAIN_LEN   = 6;
	localparam int N_DISPATCH  = N_INDEP + N_SELECT + N_CHAINS * CHAIN_LEN + `RS_DEPTH + 5;
	localparam int CYCLE_LIMIT = 20 * N_DISPATCH + 200;
	localparam int N_TAGS      = 1 << `TAG_W;
	localparam logic [`TAG_W-1:0] NEVER_TAG = `TAG_W'(N_TAGS - 1); // never a dest
	localparam int IDLE    = 0;
	localparam int PENDING = 1;
	localparam int HELD    = 2; // waits forever until squash

	logic                       clock = 1'b0;
	logic                       reset;
	logic                       squash;
	logic                       dispatch_valid;
	exec_pkg::dispatch_packet_t dispatch;
	logic                       rs_full;
	logic                       result_valid;
	exec_pkg::result_packet_t   result;

	integer            seed;
	int                cycle_count;
	int                pass_count;
	int                fail_count;
	int                test_passes;
	int                test_fails;
	int                occupancy;
	int                pending_count;
	int                tag_state [N_TAGS];
	logic [`XLEN-1:0]  exp_value [N_TAGS];
	logic [`TAG_W-1:0] next_tag;
	logic              bcast_valid; // result seen at this falling edge
	logic [`TAG_W-1:0] bcast_tag;

	exec_unit i_dut (
		.clock          (clock),
		.reset          (reset),
		.squash         (squash),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.rs_full        (rs_full),
		.result_valid   (result_valid),
		.result         (result)
	);

	always #10 clock = ~clock;

	// cycle budget for the whole run
	initial begin
		cycle_count = 0;
		while (cycle_count <= CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the run did not finish", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [`XLEN-1:0] rand_word();
		return $random(seed);
	endfunction

	// reference alu, straight from the opcode rules
	function automatic logic [`XLEN-1:0] model_alu(input exec_pkg::alu_func_e func,
			input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [4:0]         sh;
		logic [2*`XLEN-1:0] shifted;
		sh      = b[4:0];
		shifted = {{`XLEN{a[`XLEN-1]}}, a} >> sh; // sign bits fall in from the top
		case (func)
			exec_pkg::ALU_ADD:  return a + b;
			exec_pkg::ALU_SUB:  return a + ~b + `XLEN'(1);
			exec_pkg::ALU_AND:  return a & b;
			exec_pkg::ALU_OR:   return a | b;
			exec_pkg::ALU_XOR:  return a ^ b;
			exec_pkg::ALU_SLL:  return a << sh;
			exec_pkg::ALU_SRL:  return a >> sh;
			exec_pkg::ALU_SRA:  return shifted[`XLEN-1:0];
			exec_pkg::ALU_SLT: begin
				if (a[`XLEN-1] != b[`XLEN-1]) begin
					return `XLEN'(a[`XLEN-1]); // negative one is smaller
				end
				return `XLEN'(a < b);
			end
			exec_pkg::ALU_SLTU: return `XLEN'(a < b);
			default:            return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] model_result(input exec_pkg::dispatch_packet_t p,
			input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2);
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		case (p.opa_select)
			exec_pkg::OPA_IS_PC:   a = p.pc;
			exec_pkg::OPA_IS_ZERO: a = '0;
			default:               a = v1;
		endcase
		b = (p.opb_select == exec_pkg::OPB_IS_IMM) ? p.imm : v2;
		return model_alu(p.alu_func, a, b);
	endfunction

	function automatic exec_pkg::dispatch_packet_t random_packet();
		exec_pkg::dispatch_packet_t p;
		logic [`XLEN-1:0]           r;
		r            = rand_word();
		p            = '0;
		p.pc         = rand_word() & ~`XLEN'(3);
		p.imm        = {{(`XLEN-12){r[11]}}, r[11:0]}; // 12 bit immediate, extended
		p.alu_func   = exec_pkg::alu_func_e'(4'(rand_below(10)));
		p.opa_select = exec_pkg::opa_sel_e'(2'(rand_below(3)));
		p.opb_select = exec_pkg::opb_sel_e'(1'(rand_below(2)));
		return p;
	endfunction

	task automatic check_result(input exec_pkg::result_packet_t got);
		if (tag_state[got.tag] != PENDING) begin
			$display("unexpected result for tag %0d at %0t, nothing with that tag is pending",
				got.tag, $time);
			fail_count++;
		end else begin
			tag_state[got.tag] = IDLE;
			pending_count--;
			occupancy--;
			if (got.value !== exp_value[got.tag]) begin
				$display("** Error at %0t: result.value for tag %0d got %h expected %h",
					$time, got.tag, got.value, exp_value[got.tag]);
				fail_count++;
			end else begin
				pass_count++;
			end
		end
	endtask

	task automatic check_flag(input logic got, input int held);
		logic expected;
		expected = (held >= `RS_DEPTH);
		if (got !== expected) begin
			$display("** Error at %0t: rs_full got %b expected %b", $time, got, expected);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// one clock, outputs sampled where they are stable
	task automatic next_cycle();
		@(negedge clock);
		bcast_valid = 1'b0;
		if (result_valid === 1'b1) begin
			bcast_valid = 1'b1;
			bcast_tag   = result.tag;
			check_result(result);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic clear_model();
		for (int t = 0; t < N_TAGS; t++) begin
			tag_state[t] = IDLE;
		end
		pending_count = 0;
		occupancy     = 0;
	endtask

	task automatic alloc_tag(output logic [`TAG_W-1:0] tag);
		logic found;
		found = 1'b0;
		while (!found) begin
			for (int i = 0; i < N_TAGS && !found; i++) begin
				tag = next_tag + `TAG_W'(i);
				if (tag != NEVER_TAG && tag_state[tag] == IDLE &&
						!(bcast_valid && tag == bcast_tag)) begin
					found = 1'b1;
				end
			end
			if (!found) begin
				next_cycle();
			end
		end
		next_tag = tag + `TAG_W'(1);
	endtask

	// waits only on a tag whose broadcast is still to come or is on the bus now
	task automatic make_source(input logic want_wait, input logic [`TAG_W-1:0] prod,
			output exec_pkg::src_operand_t src, output logic [`XLEN-1:0] value);
		src.tag = prod;
		if (want_wait && (prod == NEVER_TAG || tag_state[prod] == PENDING ||
				(bcast_valid && bcast_tag == prod))) begin
			src.value = rand_word(); // junk until wakeup
			src.ready = 1'b0;
			value     = exp_value[prod];
		end else begin
			value     = want_wait ? exp_value[prod] : rand_word();
			src.value = value;
			src.ready = 1'b1;
		end
	endtask

	task automatic send(input exec_pkg::dispatch_packet_t p, input logic [`XLEN-1:0] v1,
			input logic [`XLEN-1:0] v2, input int state);
		exp_value[p.dest_tag] = model_result(p, v1, v2);
		tag_state[p.dest_tag] = state;
		if (state == PENDING) begin
			pending_count++;
		end
		occupancy++;
		dispatch_valid = 1'b1;
		dispatch       = p;
		next_cycle();
		dispatch_valid = 1'b0;
	endtask

	// sel below zero keeps the random selects
	task automatic dispatch_instr(input logic wait1, input logic wait2,
			input logic [`TAG_W-1:0] prod, input int sel, input int state,
			output logic [`TAG_W-1:0] tag);
		exec_pkg::dispatch_packet_t p;
		logic [`XLEN-1:0]           v1;
		logic [`XLEN-1:0]           v2;
		while (rs_full) begin
			next_cycle();
		end
		alloc_tag(tag);
		p          = random_packet();
		p.dest_tag = tag;
		if (sel >= 0) begin
			p.opa_select = exec_pkg::opa_sel_e'(2'(sel % 3));
			p.opb_select = exec_pkg::opb_sel_e'(1'(sel / 3));
		end
		make_source(wait1, prod, p.src1, v1);
		make_source(wait2, prod, p.src2, v2);
		send(p, v1, v2, state);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (pending_count > 0 && waited < 100) begin
			next_cycle();
			waited++;
		end
		for (int t = 0; t < N_TAGS; t++) begin
			if (tag_state[t] == PENDING) begin
				$display("missing result: tag %0d was dispatched but never came back", t);
				fail_count++;
				tag_state[t] = IDLE;
				pending_count--;
				occupancy--;
			end
		end
	endtask

	task automatic squash_all();
		squash = 1'b1;
		clear_model(); // anything after this edge is stale
		next_cycle();
		squash = 1'b0;
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d checks passed, %0d failed", num, name,
			pass_count - test_passes, fail_count - test_fails);
		test_passes = pass_count;
		test_fails  = fail_count;
	endtask

	initial begin
		logic [`TAG_W-1:0] tag;
		logic [`TAG_W-1:0] prev;
		int                n;
		seed           = 64;
		pass_count     = 0;
		fail_count     = 0;
		test_passes    = 0;
		test_fails     = 0;
		reset          = 1'b1;
		squash         = 1'b0;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		next_tag       = '0;
		bcast_valid    = 1'b0;
		bcast_tag      = '0;
		clear_model();
		idle(5);
		reset = 1'b0;

		for (int i = 0; i < N_INDEP; i++) begin
			dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		end
		drain();
		check_flag(rs_full, occupancy);
		report_test(1, "independent ops");

		for (int i = 0; i < N_SELECT; i++) begin
			dispatch_instr(1'b0, 1'b0, '0, i % 6, PENDING, tag); // every select pair
			idle(rand_below(3));
		end
		drain();
		report_test(2, "operand selects");

		for (int c = 0; c < N_CHAINS; c++) begin
			dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, prev);
			for (int k = 1; k < CHAIN_LEN; k++) begin
				if (c % 2 == 0) begin
					n = 0;
					// dispatch in the cycle the producer is broadcast
					while (!(bcast_valid && bcast_tag == prev) && n < 20) begin
						next_cycle();
						n++;
					end
				end else begin
					idle(rand_below(4));
				end
				dispatch_instr(1'b1, rand_below(2) == 1, prev, -1, PENDING, tag);
				prev = tag;
			end
		end
		drain();
		report_test(3, "dependency wakeup");

		for (int i = 0; i < `RS_DEPTH; i++) begin
			dispatch_instr(1'b1, 1'b0, NEVER_TAG, -1, HELD, tag);
			check_flag(rs_full, occupancy);
		end
		idle(20); // no broadcast, nothing may come back
		check_flag(rs_full, occupancy);
		report_test(4, "full flag");

		squash_all();
		dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		squash_all(); // first one in the alu, second in the issue latch
		idle(10);
		check_flag(rs_full, occupancy);
		dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		drain();
		report_test(5, "squash");

		dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		reset = 1'b1;
		clear_model();
		idle(5);
		reset = 1'b0;
		idle(10);
		check_flag(rs_full, occupancy);
		dispatch_instr(1'b0, 1'b0, '0, -1, PENDING, tag);
		drain();
		report_test(6, "reset");

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* exec_unit.f */
+incdir+design
design/exec_pkg.sv
design/alu.sv
design/fu_alu.sv
design/res_station.sv
design/exec_unit.sv
test/exec_unit_properties.sv
test/exec_unit_tb.sv

/* Makefile */
SRCS := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: run clean

run: obj_dir/Vexec_unit_tb
	@out="$$(./obj_dir/Vexec_unit_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/V%: test/%.sv exec_unit.f $(SRCS)
	verilator --binary --timing --assert -f exec_unit.f --top-module $*

clean:
	rm -rf obj_dir
